//--- common/l2_tag_pkg.sv
// L2 tag directory geometry and pseudo-LRU codes; 4 ways, 512 sets, 18-bit tags, fixed
`default_nettype none

package l2_tag_pkg;

    // cache geometry
    localparam int tag_w    = 18;
    localparam int index_w  = 9;
    localparam int num_sets = 512;
    localparam int num_ways = 4;
    localparam int way_w    = 2;
    localparam int plru_w   = 3;

    // pseudo-LRU bit positions
    localparam int plru_half_bit = 0;   // low half (ways 0/1) touched last
    localparam int plru_low_bit  = 1;   // way 0 touched last within low half
    localparam int plru_high_bit = 2;   // way 2 touched last within high half

    // touch code per way, entry [w] is the code for way w
    localparam logic [num_ways-1:0][plru_w-1:0] plru_touch_val = {
        3'b000,     // way 3
        3'b100,     // way 2
        3'b001,     // way 1
        3'b011      // way 0
    };

    // bits that a touch of way w rewrites, the rest keep their value
    localparam logic [num_ways-1:0][plru_w-1:0] plru_touch_mask = {
        3'b101,     // way 3
        3'b101,     // way 2
        3'b011,     // way 1
        3'b011      // way 0
    };

    // lookup core FSM states
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_read    = 2'd1;
    localparam logic [1:0] st_compare = 2'd2;
    localparam logic [1:0] st_write   = 2'd3;

endpackage

`default_nettype wire

//--- l2_tag_ram/l2_sram.sv
// single-port synchronous RAM; q only changes on a read, no read and write of one address at once
`timescale 1ns/10ps
`default_nettype none

module l2_sram #(
    parameter int width = 18,
    parameter int depth = 512
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic                     wren,
    input  logic                     rden,
    input  logic [width-1:0]         data,
    output logic [width-1:0]         q
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (wren)
            mem[addr] <= data;
        if (rden)
            q <= mem[addr];     // holds until the next read
    end

endmodule

`default_nettype wire

//--- l2_tag_ram/l2_tag_ram.sv
// tag, dirty and pseudo-LRU arrays; read data one cycle after rd_en, only valid bits are reset
`timescale 1ns/10ps
`default_nettype none

module l2_tag_ram import l2_tag_pkg::*; (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rd_en,
    input  logic [index_w-1:0]                 index,
    input  logic [num_ways-1:0]                way_we,
    input  logic [tag_w-1:0]                   tag_d,
    input  logic                               dirty_d,
    input  logic                               valid_d,
    input  logic                               plru_we,
    input  logic [plru_w-1:0]                  plru_d,
    output logic [num_ways-1:0][tag_w-1:0]     tag_q,
    output logic [num_ways-1:0]                dirty_q,
    output logic [num_ways-1:0]                valid_q,
    output logic [plru_w-1:0]                  plru_q
);

    logic [num_ways-1:0] valid_mem [num_sets];     // flops so reset can clear them

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        l2_sram #(
            .width (tag_w),
            .depth (num_sets)
        ) u_tag (
            .clk   (clk),
            .addr  (index),
            .wren  (way_we[w]),
            .rden  (rd_en),
            .data  (tag_d),
            .q     (tag_q[w])
        );

        l2_sram #(
            .width (1),
            .depth (num_sets)
        ) u_dirty (
            .clk   (clk),
            .addr  (index),
            .wren  (way_we[w]),
            .rden  (rd_en),
            .data  (dirty_d),
            .q     (dirty_q[w])
        );
    end

    // one field per set, shared by all ways
    l2_sram #(
        .width (plru_w),
        .depth (num_sets)
    ) u_plru (
        .clk   (clk),
        .addr  (index),
        .wren  (plru_we),
        .rden  (rd_en),
        .data  (plru_d),
        .q     (plru_q)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++)
                valid_mem[s] <= '0;
            valid_q <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_we[w])
                    valid_mem[index][w] <= valid_d;
            end
            if (rd_en)
                valid_q <= valid_mem[index];    // same timing as the RAM read
        end
    end

endmodule

`default_nettype wire

//--- rtl/l2_lookup.sv
// lookup core; one request at a time, idle/read/compare/write, write stalls while a result is held
`timescale 1ns/10ps
`default_nettype none

module l2_lookup import l2_tag_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           hold_valid,
    input  logic                           hold_write,
    input  logic [tag_w-1:0]               hold_tag,
    input  logic [index_w-1:0]             hold_index,
    output logic                           take,
    output logic                           rd_en,
    output logic [index_w-1:0]             index,
    output logic [num_ways-1:0]            way_we,
    output logic [tag_w-1:0]               tag_d,
    output logic                           dirty_d,
    output logic                           valid_d,
    output logic                           plru_we,
    output logic [plru_w-1:0]              plru_d,
    input  logic [num_ways-1:0][tag_w-1:0] tag_q,
    input  logic [num_ways-1:0]            dirty_q,
    input  logic [num_ways-1:0]            valid_q,
    input  logic [plru_w-1:0]              plru_q,
    output logic                           res_valid,
    input  logic                           res_taken,
    output logic                           res_hit,
    output logic [way_w-1:0]               res_way,
    output logic                           res_wb,
    output logic [tag_w-1:0]               res_victim_tag
);

    logic [1:0]         state;
    logic               res_pending;    // output side still holds a result
    logic               out_ready;
    logic               cur_write;
    logic [tag_w-1:0]   cur_tag;
    logic [index_w-1:0] cur_index;
    logic               hit;
    logic [way_w-1:0]   hit_way;
    logic               has_free;
    logic [way_w-1:0]   free_way;
    logic [way_w-1:0]   lru_way;
    logic [way_w-1:0]   sel_way;
    logic               new_dirty;
    logic [plru_w-1:0]  new_plru;
    logic               r_dirty;
    logic [plru_w-1:0]  r_plru;

    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        has_free = 1'b0;
        free_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin   // downward so lowest way wins
            if (valid_q[w] && (tag_q[w] == cur_tag)) begin
                hit     = 1'b1;
                hit_way = way_w'(w);
            end
            if (!valid_q[w]) begin
                has_free = 1'b1;
                free_way = way_w'(w);
            end
        end

        // tree walk of the pseudo-LRU field
        if (plru_q[plru_half_bit])
            lru_way = plru_q[plru_high_bit] ? way_w'(3) : way_w'(2);
        else
            lru_way = plru_q[plru_low_bit] ? way_w'(1) : way_w'(0);

        if (hit)
            sel_way = hit_way;
        else if (has_free)
            sel_way = free_way;
        else
            sel_way = lru_way;

        new_dirty = cur_write | (hit & dirty_q[sel_way]);
        new_plru  = (plru_q & ~plru_touch_mask[sel_way]) | plru_touch_val[sel_way];
    end

    assign out_ready = !res_pending || res_taken;
    assign take      = (state == st_read);
    assign rd_en     = take;
    assign index     = take ? hold_index : cur_index;
    assign res_valid = (state == st_write) && out_ready;
    assign way_we    = res_valid ? (num_ways'(1) << res_way) : '0;
    assign tag_d     = cur_tag;     // equals stored tag on a hit
    assign valid_d   = 1'b1;
    assign dirty_d   = r_dirty;
    assign plru_we   = res_valid;
    assign plru_d    = r_plru;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            res_pending <= 1'b0;
        end else begin
            case (state)
                st_idle:    if (hold_valid) state <= st_read;
                st_read:    state <= st_compare;
                st_compare: state <= st_write;
                st_write:   if (out_ready) state <= st_idle;
                default:    state <= st_idle;
            endcase
            if (res_valid)
                res_pending <= 1'b1;
            else if (res_taken)
                res_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cur_write <= hold_write;
            cur_tag   <= hold_tag;
            cur_index <= hold_index;
        end
        if (state == st_compare) begin
            res_hit        <= hit;
            res_way        <= sel_way;
            res_wb         <= !hit && valid_q[sel_way] && dirty_q[sel_way];
            res_victim_tag <= tag_q[sel_way];
            r_dirty        <= new_dirty;
            r_plru         <= new_plru;
        end
    end

endmodule

`default_nettype wire

//--- rtl/l2_req_port.sv
// request acceptor; four-phase req/ack, one-entry holding register, req data must be stable
`timescale 1ns/10ps
`default_nettype none

module l2_req_port import l2_tag_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  logic               req_write,
    input  logic [tag_w-1:0]   req_tag,
    input  logic [index_w-1:0] req_index,
    output logic               ack,
    output logic               hold_valid,
    output logic               hold_write,
    output logic [tag_w-1:0]   hold_tag,
    output logic [index_w-1:0] hold_index,
    input  logic               take
);

    logic accept;

    // new request only when the last handshake has closed and the slot is free
    assign accept = req && !ack && !hold_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack        <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            if (accept) begin
                ack        <= 1'b1;
                hold_valid <= 1'b1;
            end else begin
                if (!req && ack)
                    ack <= 1'b0;            // phase 4, independent of the core
                if (take)
                    hold_valid <= 1'b0;     // core has copied the request
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_write <= req_write;
            hold_tag   <= req_tag;
            hold_index <= req_index;
        end
    end

endmodule

`default_nettype wire

//--- rtl/l2_resp_port.sv
// response offerer; one-entry result register, four-phase resp_req/resp_ack, frees on ack fall
`timescale 1ns/10ps
`default_nettype none

module l2_resp_port import l2_tag_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             res_valid,
    output logic             res_taken,
    input  logic             res_hit,
    input  logic [way_w-1:0] res_way,
    input  logic             res_wb,
    input  logic [tag_w-1:0] res_victim_tag,
    output logic             resp_req,
    input  logic             resp_ack,
    output logic             resp_hit,
    output logic [way_w-1:0] resp_way,
    output logic             resp_wb,
    output logic [tag_w-1:0] resp_victim_tag
);

    logic full;

    // req already dropped, waiting for consumer to release ack
    assign res_taken = full && !resp_req && !resp_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            full     <= 1'b0;
            resp_req <= 1'b0;
        end else begin
            if (res_valid) begin
                full     <= 1'b1;
                resp_req <= 1'b1;
            end else begin
                if (resp_req && resp_ack)
                    resp_req <= 1'b0;   // phase 3
                if (res_taken)
                    full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            resp_hit        <= res_hit;
            resp_way        <= res_way;
            resp_wb         <= res_wb;
            resp_victim_tag <= res_victim_tag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/l2_tag_dir.sv
// L2 tag directory top; four-phase request and response ports, one request in flight
`timescale 1ns/10ps
`default_nettype none

module l2_tag_dir import l2_tag_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  logic               req_write,
    input  logic [tag_w-1:0]   req_tag,
    input  logic [index_w-1:0] req_index,
    output logic               ack,
    output logic               resp_req,
    input  logic               resp_ack,
    output logic               resp_hit,
    output logic [way_w-1:0]   resp_way,
    output logic               resp_wb,
    output logic [tag_w-1:0]   resp_victim_tag
);

    logic                           hold_valid;
    logic                           hold_write;
    logic [tag_w-1:0]               hold_tag;
    logic [index_w-1:0]             hold_index;
    logic                           take;
    logic                           rd_en;
    logic [index_w-1:0]             index;
    logic [num_ways-1:0]            way_we;
    logic [tag_w-1:0]               tag_d;
    logic                           dirty_d;
    logic                           valid_d;
    logic                           plru_we;
    logic [plru_w-1:0]              plru_d;
    logic [num_ways-1:0][tag_w-1:0] tag_q;
    logic [num_ways-1:0]            dirty_q;
    logic [num_ways-1:0]            valid_q;
    logic [plru_w-1:0]              plru_q;
    logic                           res_valid;
    logic                           res_taken;
    logic                           res_hit;
    logic [way_w-1:0]               res_way;
    logic                           res_wb;
    logic [tag_w-1:0]               res_victim_tag;

    l2_req_port u_req_port (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_write  (req_write),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .ack        (ack),
        .hold_valid (hold_valid),
        .hold_write (hold_write),
        .hold_tag   (hold_tag),
        .hold_index (hold_index),
        .take       (take)
    );

    l2_lookup u_lookup (
        .clk            (clk),
        .reset          (reset),
        .hold_valid     (hold_valid),
        .hold_write     (hold_write),
        .hold_tag       (hold_tag),
        .hold_index     (hold_index),
        .take           (take),
        .rd_en          (rd_en),
        .index          (index),
        .way_we         (way_we),
        .tag_d          (tag_d),
        .dirty_d        (dirty_d),
        .valid_d        (valid_d),
        .plru_we        (plru_we),
        .plru_d         (plru_d),
        .tag_q          (tag_q),
        .dirty_q        (dirty_q),
        .valid_q        (valid_q),
        .plru_q         (plru_q),
        .res_valid      (res_valid),
        .res_taken      (res_taken),
        .res_hit        (res_hit),
        .res_way        (res_way),
        .res_wb         (res_wb),
        .res_victim_tag (res_victim_tag)
    );

    l2_tag_ram u_tag_ram (
        .clk     (clk),
        .reset   (reset),
        .rd_en   (rd_en),
        .index   (index),
        .way_we  (way_we),
        .tag_d   (tag_d),
        .dirty_d (dirty_d),
        .valid_d (valid_d),
        .plru_we (plru_we),
        .plru_d  (plru_d),
        .tag_q   (tag_q),
        .dirty_q (dirty_q),
        .valid_q (valid_q),
        .plru_q  (plru_q)
    );

    l2_resp_port u_resp_port (
        .clk             (clk),
        .reset           (reset),
        .res_valid       (res_valid),
        .res_taken       (res_taken),
        .res_hit         (res_hit),
        .res_way         (res_way),
        .res_wb          (res_wb),
        .res_victim_tag  (res_victim_tag),
        .resp_req        (resp_req),
        .resp_ack        (resp_ack),
        .resp_hit        (resp_hit),
        .resp_way        (resp_way),
        .resp_wb         (resp_wb),
        .resp_victim_tag (resp_victim_tag)
    );

endmodule

`default_nettype wire

//--- sources.f
common/l2_tag_pkg.sv
l2_tag_ram/l2_sram.sv
l2_tag_ram/l2_tag_ram.sv
rtl/l2_req_port.sv
rtl/l2_lookup.sv
rtl/l2_resp_port.sv
rtl/l2_tag_dir.sv
test/l2_tag_dir_tb.sv

//--- test/l2_tag_dir_tb.sv
// random request and response delays, seed 57; checks each response against a per-set directory model
`timescale 1ns/10ps
`default_nettype none

module l2_tag_dir_tb import l2_tag_pkg::*; ();

    localparam int num_reqs       = 2000;
    localparam int cycles_per_req = 20;
    localparam int clk_period     = 10;
    localparam int reset_cycles   = 8;

    typedef struct packed {
        logic             hit;
        logic [way_w-1:0] way;
        logic             wb;
        logic [tag_w-1:0] vtag;
        logic             vtag_known;     // victim tag only means something for a valid line
    } exp_resp_t;

    logic               clk;
    logic               reset;
    logic               req;
    logic               req_write;
    logic [tag_w-1:0]   req_tag;
    logic [index_w-1:0] req_index;
    logic               ack;
    logic               resp_req;
    logic               resp_ack;
    logic               resp_hit;
    logic [way_w-1:0]   resp_way;
    logic               resp_wb;
    logic [tag_w-1:0]   resp_victim_tag;

    // reference directory state
    logic [tag_w-1:0]   m_tag   [num_sets][num_ways];
    logic               m_valid [num_sets][num_ways];
    logic               m_dirty [num_sets][num_ways];
    logic [plru_w-1:0]  m_plru  [num_sets];

    exp_resp_t expect_q[$];
    int        resp_count;
    int        wb_count;
    int        hit_count;
    int        ack_lag;

    l2_tag_dir uut (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .req_write       (req_write),
        .req_tag         (req_tag),
        .req_index       (req_index),
        .ack             (ack),
        .resp_req        (resp_req),
        .resp_ack        (resp_ack),
        .resp_hit        (resp_hit),
        .resp_way        (resp_way),
        .resp_wb         (resp_wb),
        .resp_victim_tag (resp_victim_tag)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    function automatic logic [plru_w-1:0] touch_plru(input logic [plru_w-1:0] p, input int w);
        logic [plru_w-1:0] r;
        r = p;
        case (w)
            0: r[1:0] = 2'b11;
            1: r[1:0] = 2'b01;
            2: {r[2], r[0]} = 2'b10;
            default: {r[2], r[0]} = 2'b00;
        endcase
        return r;
    endfunction

    function automatic int pick_lru_way(input logic [plru_w-1:0] p);
        if (p[0])
            return p[2] ? 3 : 2;    // low half was used last
        return p[1] ? 1 : 0;
    endfunction

    // applies one request to the model and returns what the DUT must answer
    function automatic exp_resp_t apply_model(input logic wr, input logic [tag_w-1:0] tg,
                                              input logic [index_w-1:0] ix);
        exp_resp_t r;
        logic      hit;
        int        way;
        hit = 1'b0;
        way = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (!hit && m_valid[ix][w] && m_tag[ix][w] == tg) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            for (int w = num_ways - 1; w >= 0; w--)
                if (!m_valid[ix][w])
                    way = w;        // lowest invalid way
            if (way < 0)
                way = pick_lru_way(m_plru[ix]);
        end
        r.hit        = hit;
        r.way        = way_w'(way);
        r.wb         = !hit && m_valid[ix][way] && m_dirty[ix][way];
        r.vtag       = m_tag[ix][way];
        r.vtag_known = m_valid[ix][way];
        if (hit) begin
            m_dirty[ix][way] = m_dirty[ix][way] | wr;
        end else begin
            m_tag[ix][way]   = tg;
            m_valid[ix][way] = 1'b1;
            m_dirty[ix][way] = wr;
        end
        m_plru[ix] = touch_plru(m_plru[ix], way);
        return r;
    endfunction

    function automatic logic [index_w-1:0] index_of(input int k);
        case (k)
            0: return 9'h003;
            1: return 9'h0a4;
            2: return 9'h155;
            default: return 9'h1fe;
        endcase
    endfunction

    task automatic send_request(input logic wr, input logic [tag_w-1:0] tg,
                                input logic [index_w-1:0] ix);
        @(posedge clk);
        req       <= 1'b1;
        req_write <= wr;
        req_tag   <= tg;
        req_index <= ix;
        do @(posedge clk); while (!ack);
        req <= 1'b0;
        do @(posedge clk); while (ack);
    endtask

    // driver, model and end of run
    initial begin
        exp_resp_t e;
        logic      wr;
        logic [tag_w-1:0]   tg;
        logic [index_w-1:0] ix;
        void'($urandom(57));
        clk        = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        req_write  = 1'b0;
        req_tag    = '0;
        req_index  = '0;
        resp_ack   = 1'b0;
        resp_count = 0;
        wb_count   = 0;
        hit_count  = 0;
        for (int s = 0; s < num_sets; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        idle_cycles(reset_cycles);
        reset <= 1'b0;
        @(posedge clk);
        check_value("ack", ack, 1'b0);
        check_value("resp_req", resp_req, 1'b0);
        for (int n = 0; n < num_reqs; n++) begin
            idle_cycles($urandom_range(0, 3));
            wr = 1'($urandom_range(0, 1));
            tg = 18'h2a5c0 + tag_w'($urandom_range(0, 7) * 18'h0133);
            ix = index_of($urandom_range(0, 3));
            e  = apply_model(wr, tg, ix);
            expect_q.push_back(e);
            send_request(wr, tg, ix);
        end
        while (resp_count < num_reqs)
            @(posedge clk);
        idle_cycles(10);
        $display("hits %0d, writebacks %0d, responses %0d", hit_count, wb_count, resp_count);
        if (wb_count == 0)
            abort_run("no dirty eviction was exercised");
        else begin
            $display("all tests passed");
            $finish;
        end
    end

    // consumer with random ack delay
    initial begin
        exp_resp_t e;
        @(negedge reset);
        forever begin
            do @(posedge clk); while (!resp_req);
            if (expect_q.size() == 0)
                abort_run("response offered with no request outstanding");
            e = expect_q.pop_front();
            check_value("resp_hit", resp_hit, e.hit);
            check_value("resp_way", resp_way, e.way);
            check_value("resp_wb", resp_wb, e.wb);
            if (e.vtag_known)
                check_value("resp_victim_tag", resp_victim_tag, e.vtag);
            resp_count++;
            hit_count += int'(e.hit);
            wb_count  += int'(e.wb);
            idle_cycles($urandom_range(0, 3));
            resp_ack <= 1'b1;
            do @(posedge clk); while (resp_req);
            resp_ack <= 1'b0;
        end
    end

    // ack may trail a dropped req by one cycle only
    always @(posedge clk) begin
        if (reset) begin
            ack_lag = 0;
        end else begin
            if (ack && !req)
                ack_lag++;
            else
                ack_lag = 0;
            if (ack_lag > 1)
                abort_run("ack stayed high for more than one cycle after req fell");
        end
    end

    initial begin
        #((num_reqs * cycles_per_req + reset_cycles) * clk_period);
        abort_run("timeout: responses did not complete within the expected run time");
    end

endmodule

`default_nettype wire
